// File: hdl/riot_consts.svh
`ifndef RIOT_CONSTS_SVH
`define RIOT_CONSTS_SVH

// Bus data width
`define RIOT_DATA_W 8

// On-chip RAM, 128 bytes
`define RIOT_RAM_DEPTH 128
`define RIOT_RAM_AW 7

// Prescale shifts, clocks per count is 1 << shift
`define RIOT_PRE_SHIFT0 0
`define RIOT_PRE_SHIFT1 3
`define RIOT_PRE_SHIFT2 6
`define RIOT_PRE_SHIFT3 10

`endif

// File: hdl/riotBusPkg.sv
`default_nettype none

`include "riot_consts.svh"

package riotBusPkg;

   // One CPU access on the request channel
   typedef struct packed {
      logic ramSel; // High for RAM, low for I/O and timer
      logic write;
      logic [`RIOT_RAM_AW-1:0] addr;
      logic [`RIOT_DATA_W-1:0] wdata;
   } busReqT;

   typedef struct packed {
      logic [`RIOT_DATA_W-1:0] rdata;
   } busRspT;

   // Port register select, order follows addr[1:0]
   typedef enum logic [1:0] {DRA = 2'd0, DDRA, DRB, DDRB} portSelT;

   typedef struct packed {
      logic en;
      portSelT sel;
      logic [`RIOT_DATA_W-1:0] data;
   } portWrT;

   // PA7 edge detector setup
   typedef struct packed {
      logic en;
      logic rising; // 1 selects rising edge
      logic irqEn;
   } edgeCfgT;

endpackage

`default_nettype wire

// File: hdl/riotTimerPkg.sv
`default_nettype none

`include "riot_consts.svh"

package riotTimerPkg;

   // Clocks per count, order follows addr[1:0] of a timer write
   typedef enum logic [1:0] {DIV1 = 2'd0, DIV8, DIV64, DIV1024} intervalT;

   // Timer write command
   typedef struct packed {
      logic en;
      intervalT interval;
      logic irqEn;
      logic [`RIOT_DATA_W-1:0] value; // Start count
   } timerLoadT;

endpackage

`default_nettype wire

// File: hdl/riotRam.sv
`default_nettype none

`include "riot_consts.svh"

module riotRam (
   input  wire logic CLK,
   input  wire logic we,
   input  wire logic [`RIOT_RAM_AW-1:0] addr,
   input  wire logic [`RIOT_DATA_W-1:0] wdata,
   output logic [`RIOT_DATA_W-1:0] rdata
);

   // Byte array, contents undefined at power-up
   logic [`RIOT_DATA_W-1:0] mem [`RIOT_RAM_DEPTH];

   // Single port, registered output
   always_ff @(posedge CLK) begin
      if (we) begin
         mem[addr] <= wdata;
         rdata <= wdata; // Write-first
      end else begin
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// File: hdl/riotPorts.sv
`default_nettype none

`include "riot_consts.svh"

module riotPorts import riotBusPkg::*; (
   input  wire logic CLK,
   input  wire logic rstN,
   input  wire portWrT portWr,
   input  wire portSelT portRdSel,
   input  wire edgeCfgT edgeCfg,
   input  wire logic pa7Clr,
   input  wire logic [`RIOT_DATA_W-1:0] paIn,
   input  wire logic [`RIOT_DATA_W-1:0] pbIn,
   output logic [`RIOT_DATA_W-1:0] paOut,
   output logic [`RIOT_DATA_W-1:0] pbOut,
   output logic [`RIOT_DATA_W-1:0] portRdData,
   output logic pa7Flag,
   output logic pa7IrqEn
);

   logic [`RIOT_DATA_W-1:0] dra, ddra, drb, ddrb;
   logic [`RIOT_DATA_W-1:0] paView, pbView; // What a CPU read sees
   logic pa7, pa7Q;
   logic risingQ;
   logic edgeHit;

   // Data and direction registers
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         dra <= '0;
         ddra <= '0;
         drb <= '0;
         ddrb <= '0;
      end else if (portWr.en) begin
         case (portWr.sel)
            DRA:  dra <= portWr.data;
            DDRA: ddra <= portWr.data;
            DRB:  drb <= portWr.data;
            DDRB: ddrb <= portWr.data;
         endcase
      end
   end

   // Outputs drive only where the direction bit is set
   assign paOut = dra & ddra;
   assign pbOut = drb & ddrb;

   // Inputs from pins, outputs from the register
   assign paView = (paIn & ~ddra) | (dra & ddra);
   assign pbView = (pbIn & ~ddrb) | (drb & ddrb);

   always_comb begin
      case (portRdSel)
         DRA:     portRdData = paView;
         DDRA:    portRdData = ddra;
         DRB:     portRdData = pbView;
         default: portRdData = ddrb;
      endcase
   end

   assign pa7 = paView[`RIOT_DATA_W-1]; // Effective PA7
   assign edgeHit = (pa7 != pa7Q) && (pa7 == risingQ);

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         pa7Q <= 1'b0;
         risingQ <= 1'b0;
         pa7IrqEn <= 1'b0;
         pa7Flag <= 1'b0;
      end else begin
         pa7Q <= pa7;
         if (edgeCfg.en) begin
            risingQ <= edgeCfg.rising;
            pa7IrqEn <= edgeCfg.irqEn;
         end
         if (pa7Clr) begin
            pa7Flag <= 1'b0; // Clear wins
         end else if (edgeHit) begin
            pa7Flag <= 1'b1; // Sticky until status read
         end
      end
   end

   // A status read and a port write never share a request
   clrVsWr: assert property (@(posedge CLK) disable iff (!rstN)
      !(pa7Clr && portWr.en));

endmodule

`default_nettype wire

// File: hdl/riotTimer.sv
`default_nettype none

`include "riot_consts.svh"

module riotTimer import riotTimerPkg::*; (
   input  wire logic CLK,
   input  wire logic rstN,
   input  wire timerLoadT timerLoad,
   input  wire logic timerClr,
   output logic [`RIOT_DATA_W-1:0] timerValue,
   output logic timerFlag,
   output logic timerIrqEn
);

   localparam int preW = `RIOT_PRE_SHIFT3; // Widest prescale

   logic [preW-1:0] preCnt;
   logic [`RIOT_DATA_W-1:0] countQ;
   intervalT intervalQ;
   logic runQ; // Idle until the first load
   logic freeRunQ; // Single-clock decrement after underflow
   logic tick, underflow;

   // Prescale reload for an interval
   function automatic logic [preW-1:0] preLoad(intervalT iv);
      case (iv)
         DIV1:    preLoad = preW'((1 << `RIOT_PRE_SHIFT0) - 1);
         DIV8:    preLoad = preW'((1 << `RIOT_PRE_SHIFT1) - 1);
         DIV64:   preLoad = preW'((1 << `RIOT_PRE_SHIFT2) - 1);
         default: preLoad = preW'((1 << `RIOT_PRE_SHIFT3) - 1);
      endcase
   endfunction

   assign tick = runQ && (preCnt == '0);
   assign underflow = tick && (countQ == '0);

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         preCnt <= '0;
         countQ <= '0;
         intervalQ <= DIV1;
         runQ <= 1'b0;
         freeRunQ <= 1'b0;
         timerIrqEn <= 1'b0;
         timerFlag <= 1'b0;
      end else if (timerLoad.en) begin
         countQ <= timerLoad.value;
         intervalQ <= timerLoad.interval;
         preCnt <= preLoad(timerLoad.interval);
         timerIrqEn <= timerLoad.irqEn;
         runQ <= 1'b1;
         freeRunQ <= 1'b0;
         timerFlag <= 1'b0; // Load clears the flag
      end else begin
         if (tick) begin
            countQ <= countQ - 1'b1; // 0 wraps to 255
            if (underflow || freeRunQ) begin
               preCnt <= '0;
            end else begin
               preCnt <= preLoad(intervalQ);
            end
            if (underflow) begin
               freeRunQ <= 1'b1;
            end
         end else if (runQ) begin
            preCnt <= preCnt - 1'b1;
         end
         if (timerClr) begin
            timerFlag <= 1'b0; // Clear beats underflow
         end else if (underflow) begin
            timerFlag <= 1'b1;
         end
      end
   end

   assign timerValue = countQ;

   // Counter stays within the current interval
   preRange: assert property (@(posedge CLK) disable iff (!rstN)
      preCnt <= preLoad(intervalQ));

endmodule

`default_nettype wire

// File: hdl/riotBusCtrl.sv
`default_nettype none

`include "riot_consts.svh"

module riotBusCtrl import riotBusPkg::*, riotTimerPkg::*; (
   input  wire logic CLK,
   input  wire logic rstN,
   input  wire busReqT req,
   input  wire logic reqValid,
   output logic reqReady,
   output busRspT rsp,
   output logic rspValid,
   input  wire logic rspReady,
   output portWrT portWr,
   output portSelT portRdSel,
   output edgeCfgT edgeCfg,
   output logic pa7Clr,
   input  wire logic [`RIOT_DATA_W-1:0] portRdData,
   input  wire logic pa7Flag,
   input  wire logic pa7IrqEn,
   output timerLoadT timerLoad,
   output logic timerClr,
   input  wire logic [`RIOT_DATA_W-1:0] timerValue,
   input  wire logic timerFlag,
   input  wire logic timerIrqEn,
   output logic irqN
);

   logic accept;
   logic ioAcc, ioHi; // I/O access, upper register group
   logic ramWe;
   logic [`RIOT_RAM_AW-1:0] ramAddr, addrQ;
   logic [`RIOT_DATA_W-1:0] ramRdata;
   logic [`RIOT_DATA_W-1:0] capD, capQ; // Non-RAM read data
   logic ramSrcQ;

   assign reqReady = !rspValid || rspReady; // Stall only on a held response
   assign accept = reqValid && reqReady;

   assign ioAcc = accept && !req.ramSel;
   assign ioHi = ioAcc && req.addr[2];

   // Commands to the neighbors for each accepted request
   always_comb begin
      portRdSel = portSelT'(req.addr[1:0]);
      portWr.en = ioAcc && !req.addr[2] && req.write;
      portWr.sel = portSelT'(req.addr[1:0]);
      portWr.data = req.wdata;
      edgeCfg.en = ioHi && req.write && !req.addr[4];
      edgeCfg.rising = req.addr[0];
      edgeCfg.irqEn = req.addr[1];
      timerLoad.en = ioHi && req.write && req.addr[4];
      timerLoad.interval = intervalT'(req.addr[1:0]);
      timerLoad.irqEn = req.addr[3];
      timerLoad.value = req.wdata;
   end

   assign timerClr = ioHi && !req.write && !req.addr[0]; // Timer read
   assign pa7Clr = ioHi && !req.write && req.addr[0]; // Status read

   // RAM keeps the last read address so a held response stays put
   assign ramWe = accept && req.ramSel && req.write;
   assign ramAddr = accept ? req.addr : addrQ;

   riotRam u_ram (
      .CLK   (CLK),
      .we    (ramWe),
      .addr  (ramAddr),
      .wdata (req.wdata),
      .rdata (ramRdata)
   );

   always_comb begin
      if (!req.addr[2]) begin
         capD = portRdData;
      end else if (!req.addr[0]) begin
         capD = timerValue;
      end else begin
         capD = {timerFlag, pa7Flag, {(`RIOT_DATA_W-2){1'b0}}}; // Flags before the clear
      end
   end

   always_ff @(posedge CLK) begin
      if (accept) begin
         addrQ <= req.addr;
         ramSrcQ <= req.ramSel;
         capQ <= capD;
      end
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         rspValid <= 1'b0;
      end else if (accept && !req.write) begin
         rspValid <= 1'b1; // Read answered next cycle
      end else if (rspReady) begin
         rspValid <= 1'b0;
      end
   end

   assign rsp.rdata = ramSrcQ ? ramRdata : capQ;

   assign irqN = !((timerFlag && timerIrqEn) || (pa7Flag && pa7IrqEn));

   // Held response must not move
   rspHold: assert property (@(posedge CLK) disable iff (!rstN)
      rspValid && !rspReady |=> rspValid && $stable(rsp));

endmodule

`default_nettype wire

// File: hdl/riot.sv
`default_nettype none

`include "riot_consts.svh"

module riot import riotBusPkg::*, riotTimerPkg::*; (
   input  wire logic CLK,
   input  wire logic rstN,
   input  wire busReqT req,
   input  wire logic reqValid,
   output logic reqReady,
   output busRspT rsp,
   output logic rspValid,
   input  wire logic rspReady,
   input  wire logic [`RIOT_DATA_W-1:0] paIn,
   input  wire logic [`RIOT_DATA_W-1:0] pbIn,
   output logic [`RIOT_DATA_W-1:0] paOut,
   output logic [`RIOT_DATA_W-1:0] pbOut,
   output logic irqN
);

   portWrT portWr;
   portSelT portRdSel;
   edgeCfgT edgeCfg;
   logic pa7Clr, pa7Flag, pa7IrqEn;
   logic [`RIOT_DATA_W-1:0] portRdData;
   timerLoadT timerLoad;
   logic timerClr, timerFlag, timerIrqEn;
   logic [`RIOT_DATA_W-1:0] timerValue;

   // Decode, RAM and response path
   riotBusCtrl u_busCtrl (
      .CLK        (CLK),
      .rstN       (rstN),
      .req        (req),
      .reqValid   (reqValid),
      .reqReady   (reqReady),
      .rsp        (rsp),
      .rspValid   (rspValid),
      .rspReady   (rspReady),
      .portWr     (portWr),
      .portRdSel  (portRdSel),
      .edgeCfg    (edgeCfg),
      .pa7Clr     (pa7Clr),
      .portRdData (portRdData),
      .pa7Flag    (pa7Flag),
      .pa7IrqEn   (pa7IrqEn),
      .timerLoad  (timerLoad),
      .timerClr   (timerClr),
      .timerValue (timerValue),
      .timerFlag  (timerFlag),
      .timerIrqEn (timerIrqEn),
      .irqN       (irqN)
   );

   riotPorts u_ports (
      .CLK        (CLK),
      .rstN       (rstN),
      .portWr     (portWr),
      .portRdSel  (portRdSel),
      .edgeCfg    (edgeCfg),
      .pa7Clr     (pa7Clr),
      .paIn       (paIn),
      .pbIn       (pbIn),
      .paOut      (paOut),
      .pbOut      (pbOut),
      .portRdData (portRdData),
      .pa7Flag    (pa7Flag),
      .pa7IrqEn   (pa7IrqEn)
   );

   riotTimer u_timer (
      .CLK        (CLK),
      .rstN       (rstN),
      .timerLoad  (timerLoad),
      .timerClr   (timerClr),
      .timerValue (timerValue),
      .timerFlag  (timerFlag),
      .timerIrqEn (timerIrqEn)
   );

endmodule

`default_nettype wire

// File: tb/riotTests.svh
`ifndef RIOT_TESTS_SVH
`define RIOT_TESTS_SVH

task automatic resetStateTest();
   startTest("reset");
   @(negedge CLK);
   if (reqReady !== 1'b1 || rspValid !== 1'b0) reportFailure("handshake not idle after reset");
   checkIrq("irqN", 1'b1, irqN);
   checkPins("paOut", 8'h00, paOut); // All registers cleared
   checkPins("pbOut", 8'h00, pbOut);
   endTest();
endtask

task automatic ramTest();
   logic [7:0] memModel [`RIOT_RAM_DEPTH];
   logic [6:0] addrs [16];
   busRspT r;
   int i;
   startTest("ram");
   for (i = 0; i < 16; i++) begin
      addrs[i] = 7'(randBits(7));
      memModel[addrs[i]] = 8'(randBits(8)); // Repeats keep the last value
      busWrite(1'b1, addrs[i], memModel[addrs[i]]);
   end
   for (i = 0; i < 16; i++) begin
      busRead(1'b1, addrs[i], r);
      checkRsp("readback", rspOf(memModel[addrs[i]]), r);
   end
   endTest();
endtask

task automatic portTest();
   logic [7:0] dra, ddra, drb, ddrb;
   logic [7:0] expA, expB; // Expected read data
   busRspT r;
   int i;
   int k;
   startTest("ports");
   for (i = 0; i < 4; i++) begin
      ddra = 8'(randBits(8));
      dra = 8'(randBits(8));
      ddrb = 8'(randBits(8));
      drb = 8'(randBits(8));
      busWrite(1'b0, 7'h01, ddra);
      busWrite(1'b0, 7'h00, dra);
      busWrite(1'b0, 7'h03, ddrb);
      busWrite(1'b0, 7'h02, drb);
      @(negedge CLK);
      paIn = 8'(randBits(8));
      pbIn = 8'(randBits(8));
      @(negedge CLK);
      checkPins("paOut", dra & ddra, paOut); // Drive only output bits
      checkPins("pbOut", drb & ddrb, pbOut);
      for (k = 0; k < 8; k++) begin
         expA[k] = ddra[k] ? dra[k] : paIn[k]; // Register bit if output, pin if input
         expB[k] = ddrb[k] ? drb[k] : pbIn[k];
      end
      busRead(1'b0, 7'h00, r);
      checkRsp("DRA read", rspOf(expA), r);
      busRead(1'b0, 7'h02, r);
      checkRsp("DRB read", rspOf(expB), r);
   end
   endTest();
endtask

task automatic pa7Test();
   busRspT r;
   startTest("pa7 edge");
   busWrite(1'b0, 7'h01, 8'h00); // PA all inputs
   @(negedge CLK);
   paIn = 8'h00;
   busWrite(1'b0, 7'h07, 8'h00); // Rising edge, irq on
   repeat (3) @(negedge CLK);
   busRead(1'b0, 7'h05, r); // Drop any flag left from the port test
   checkIrq("irqN idle", 1'b1, irqN);
   @(negedge CLK);
   paIn[7] = 1'b1;
   repeat (3) @(negedge CLK);
   checkIrq("irqN after rise", 1'b0, irqN);
   busRead(1'b0, 7'h05, r);
   checkRsp("status after rise", rspOf(8'h40), r);
   busRead(1'b0, 7'h05, r);
   checkRsp("status after clear", rspOf(8'h00), r);
   checkIrq("irqN after clear", 1'b1, irqN);
   @(negedge CLK);
   paIn[7] = 1'b0; // Wrong edge
   repeat (3) @(negedge CLK);
   busRead(1'b0, 7'h05, r);
   checkRsp("status after fall", rspOf(8'h00), r);
   checkIrq("irqN after fall", 1'b1, irqN);
   endTest();
endtask

task automatic timerTest();
   busRspT r;
   startTest("timer");
   busWrite(1'b0, 7'h1C, 8'd3); // DIV1, irq on
   repeat (20) @(negedge CLK);
   checkIrq("irqN after underflow", 1'b0, irqN);
   busRead(1'b0, 7'h05, r);
   checkRsp("status", rspOf(8'h80), r);
   busRead(1'b0, 7'h04, r); // Value is free-running by now
   checkIrq("irqN after timer read", 1'b1, irqN);
   busWrite(1'b0, 7'h17, 8'd200); // DIV1024, irq off
   repeat (30) @(negedge CLK);
   busRead(1'b0, 7'h04, r);
   checkRsp("slow count", rspOf((r.rdata == 8'd199) ? 8'd199 : 8'd200), r);
   endTest();
endtask

task automatic backPressureTest();
   logic [7:0] a, b;
   busRspT r;
   int i;
   startTest("backpressure");
   a = 8'(randBits(8));
   b = ~a; // Differs from a in every bit
   busWrite(1'b1, 7'h05, a);
   busWrite(1'b1, 7'h06, b);
   @(negedge CLK);
   rspReady = 1'b0;
   issue(makeReq(1'b1, 1'b0, 7'h05, '0));
   req = makeReq(1'b1, 1'b0, 7'h06, '0); // Second read waits behind the held one
   for (i = 0; i < 4; i++) begin
      if (rspValid !== 1'b1) reportFailure("rspValid dropped while response held");
      if (reqReady !== 1'b0) reportFailure("reqReady high while response held");
      checkRsp("held rsp", rspOf(a), rsp);
      @(negedge CLK);
      if (accepted) reportFailure("request accepted while response held");
   end
   rspReady = 1'b1;
   issue(makeReq(1'b1, 1'b0, 7'h06, '0));
   reqValid = 1'b0;
   if (rspQ.size() != 1) reportFailure("held response did not transfer exactly once");
   waitRsp(2);
   checkRsp("first after release", rspOf(a), rspQ.pop_front());
   checkRsp("second after release", rspOf(b), rspQ.pop_front());
   @(negedge CLK);
   issue(makeReq(1'b1, 1'b0, 7'h05, '0)); // Back to back
   issue(makeReq(1'b1, 1'b0, 7'h06, '0));
   reqValid = 1'b0;
   waitRsp(2);
   checkRsp("back to back 1", rspOf(a), rspQ.pop_front());
   checkRsp("back to back 2", rspOf(b), rspQ.pop_front());
   endTest();
endtask

`endif

// File: tb/riotTb.sv
`default_nettype none

`include "riot_consts.svh"

module riotTb import riotBusPkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int maxCycles = 4000; // Sum of test lengths, with margin

   logic CLK;
   logic rstN;
   busReqT req;
   logic reqValid, reqReady;
   busRspT rsp;
   logic rspValid, rspReady;
   logic [`RIOT_DATA_W-1:0] paIn, pbIn, paOut, pbOut;
   logic irqN;

   logic [31:0] lfsr = 32'he3763bfd;
   logic accepted; // Request transferred at the last rising edge
   busRspT rspQ[$]; // Responses in transfer order
   int cycles = 0;
   int errCount = 0;
   int checkCount = 0;
   int testCount = 0;
   int testErrs;
   string curTest;

   riot u_riot (
      .CLK      (CLK),
      .rstN     (rstN),
      .req      (req),
      .reqValid (reqValid),
      .reqReady (reqReady),
      .rsp      (rsp),
      .rspValid (rspValid),
      .rspReady (rspReady),
      .paIn     (paIn),
      .pbIn     (pbIn),
      .paOut    (paOut),
      .pbOut    (pbOut),
      .irqN     (irqN)
   );

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // Handshake monitor, sees pre-edge values
   always @(posedge CLK) begin
      accepted <= reqValid && reqReady;
      if (rspValid && rspReady) begin
         rspQ.push_back(rsp);
      end
   end

   always @(posedge CLK) begin
      cycles++;
      if (cycles >= maxCycles) begin
         $display("Timeout: no finish within %0d cycles, stuck in %s", maxCycles, curTest);
         $display("Testbench failed");
         $finish;
      end
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic busReqT makeReq(input logic ramSel, input logic write,
                                      input logic [`RIOT_RAM_AW-1:0] addr,
                                      input logic [`RIOT_DATA_W-1:0] wdata);
      busReqT r;
      r.ramSel = ramSel;
      r.write = write;
      r.addr = addr;
      r.wdata = wdata;
      return r;
   endfunction

   function automatic busRspT rspOf(input logic [`RIOT_DATA_W-1:0] d);
      busRspT r;
      r.rdata = d;
      return r;
   endfunction

   task automatic checkRsp(input string what, input busRspT exp, input busRspT act);
      checkCount++;
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %02h, actual %02h", curTest, what, exp.rdata,
                  act.rdata);
         errCount++;
         testErrs++;
      end
   endtask

   task automatic checkPins(input string what, input logic [`RIOT_DATA_W-1:0] exp,
                            input logic [`RIOT_DATA_W-1:0] act);
      checkCount++;
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %02h, actual %02h", curTest, what, exp, act);
         errCount++;
         testErrs++;
      end
   endtask

   task automatic checkIrq(input string what, input logic exp, input logic act);
      checkCount++;
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %b, actual %b", curTest, what, exp, act);
         errCount++;
         testErrs++;
      end
   endtask

   task automatic reportFailure(input string what);
      $display("%s: %s", curTest, what);
      errCount++;
      testErrs++;
   endtask

   task automatic startTest(input string name);
      curTest = name;
      testErrs = 0;
   endtask

   task automatic endTest();
      testCount++;
      $display("%-12s %s, %0d errors", curTest, (testErrs == 0) ? "ok" : "FAILED", testErrs);
   endtask

   // Caller sits at a falling edge, leaves reqValid high on return
   task automatic issue(input busReqT r);
      req = r;
      reqValid = 1'b1;
      do @(negedge CLK); while (!accepted);
   endtask

   task automatic waitRsp(input int n);
      while (rspQ.size() < n) @(negedge CLK);
   endtask

   task automatic busWrite(input logic ramSel, input logic [`RIOT_RAM_AW-1:0] addr,
                           input logic [`RIOT_DATA_W-1:0] data);
      @(negedge CLK);
      issue(makeReq(ramSel, 1'b1, addr, data));
      reqValid = 1'b0;
   endtask

   task automatic busRead(input logic ramSel, input logic [`RIOT_RAM_AW-1:0] addr,
                          output busRspT r);
      @(negedge CLK);
      issue(makeReq(ramSel, 1'b0, addr, '0));
      reqValid = 1'b0;
      waitRsp(1);
      r = rspQ.pop_front();
   endtask

   `include "riotTests.svh"

   initial begin
      rstN = 1'b0;
      req = '0;
      reqValid = 1'b0;
      rspReady = 1'b1;
      paIn = '0;
      pbIn = '0;
      curTest = "reset";
      repeat (5) @(negedge CLK);
      rstN = 1'b1;
      resetStateTest();
      ramTest();
      portTest();
      pa7Test();
      timerTest();
      backPressureTest();
      $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
+incdir+tb
hdl/riotBusPkg.sv
hdl/riotTimerPkg.sv
hdl/riotRam.sv
hdl/riotPorts.sv
hdl/riotTimer.sv
hdl/riotBusCtrl.sv
hdl/riot.sv
tb/riotTb.sv
